//--- common/dbg_params.svh
`ifndef DBG_PARAMS_SVH
`define DBG_PARAMS_SVH

// Command bytes from the host
`define DBG_CMD_RESET     8'h01
`define DBG_CMD_START     8'h02
`define DBG_CMD_HALT      8'h03
`define DBG_CMD_READ      8'h04
`define DBG_CMD_WRITE     8'h05

// Header field widths
`define DBG_ADDR_W        10
`define DBG_LEN_W         10

// Memory word widths and bytes per word
`define DBG_DWORD_W       32
`define DBG_PWORD_W       16
`define DBG_DMEM_BYTES    4
`define DBG_PMEM_BYTES    2

`define DBG_MEMSEL_BIT    2     // In the address high byte, write only

`define DBG_CLKS_PER_BIT  16    // UART bit time

`endif

//--- common/dbg_pkg.sv
`include "dbg_params.svh"

package dbg_pkg;

    typedef logic [7:0]              byte_t;   // One UART byte
    typedef logic [`DBG_ADDR_W-1:0]  addr_t;   // Word address
    typedef logic [`DBG_LEN_W-1:0]   len_t;    // Word count
    typedef logic [`DBG_DWORD_W-1:0] dword_t;  // Data memory word
    typedef logic [`DBG_PWORD_W-1:0] pword_t;  // Program memory word

    typedef enum logic [2:0]
    {
        ST_IDLE,
        ST_ADDR_HI,
        ST_ADDR_LO,
        ST_LEN_HI,
        ST_LEN_LO,
        ST_PULSE,
        ST_BUSY
    } dec_state_t;

    typedef enum logic [2:0]
    {
        BR_IDLE,
        BR_COLLECT,
        BR_COMMIT,
        BR_FETCH,
        BR_LOAD,
        BR_SEND,
        BR_WAIT
    } bridge_state_t;

endpackage

//--- common/xfer_if.sv
`timescale 1ns/1ps

interface xfer_if
    import dbg_pkg::*;
();

    logic  start;     // One-cycle launch pulse
    logic  is_read;
    logic  to_pmem;   // Write target is program memory
    addr_t base;
    len_t  count;
    logic  done;      // One-cycle end of transfer

    modport decoder
    (
        output start, is_read, to_pmem, base, count,
        input  done
    );

    modport bridge
    (
        input  start, is_read, to_pmem, base, count,
        output done
    );

endinterface

//--- uart/uart_rx.sv
`timescale 1ns/1ps
`include "dbg_params.svh"

module uart_rx
    import dbg_pkg::*;
(
    input  logic  i_clk,
    input  logic  i_reset_n,
    input  logic  i_rx,
    output byte_t o_rx_byte,
    output logic  o_rx_valid
);

    localparam int CNT_W = $clog2(`DBG_CLKS_PER_BIT);

    logic             rx_meta;
    logic             rx_sync;
    logic             active;     // Frame in progress
    logic [CNT_W-1:0] tick_cnt;   // Clocks to the next bit center
    logic [3:0]       bit_idx;    // 0 start, 1 to 8 data, 9 stop
    byte_t            shift_reg;

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            rx_meta    <= 1'b1;
            rx_sync    <= 1'b1;
            active     <= 1'b0;
            tick_cnt   <= '0;
            bit_idx    <= '0;
            o_rx_valid <= 1'b0;
        end
        else
        begin
            rx_meta    <= i_rx;
            rx_sync    <= rx_meta;
            o_rx_valid <= 1'b0;
            if (!active)
            begin
                if (!rx_sync)
                begin
                    active   <= 1'b1;
                    tick_cnt <= CNT_W'(`DBG_CLKS_PER_BIT / 2 - 1);  // Half a bit to the center
                    bit_idx  <= '0;
                end
            end
            else if (tick_cnt != '0)
                tick_cnt <= tick_cnt - 1'b1;
            else
            begin
                tick_cnt <= CNT_W'(`DBG_CLKS_PER_BIT - 1);
                bit_idx  <= bit_idx + 1'b1;
                if (bit_idx == 4'd0)
                    active <= !rx_sync;  // Line back high means a glitch
                else if (bit_idx == 4'd9)
                begin
                    active     <= 1'b0;
                    o_rx_valid <= rx_sync;  // Framing error drops the byte
                    o_rx_byte  <= shift_reg;
                end
                else
                    shift_reg <= {rx_sync, shift_reg[7:1]};  // LSB first
            end
        end
    end

endmodule

//--- uart/uart_tx.sv
`timescale 1ns/1ps
`include "dbg_params.svh"

module uart_tx
    import dbg_pkg::*;
(
    input  logic  i_clk,
    input  logic  i_reset_n,
    input  byte_t i_tx_byte,
    input  logic  i_tx_start,
    output logic  o_tx,
    output logic  o_busy
);

    localparam int CNT_W = $clog2(`DBG_CLKS_PER_BIT);

    logic [9:0]       frame;      // Stop, data, start
    logic [CNT_W-1:0] tick_cnt;
    logic [3:0]       bits_left;

    assign o_tx = o_busy ? frame[0] : 1'b1;  // Idle line is high

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            o_busy    <= 1'b0;
            tick_cnt  <= '0;
            bits_left <= '0;
        end
        else if (!o_busy)
        begin
            if (i_tx_start)
            begin
                frame     <= {1'b1, i_tx_byte, 1'b0};
                o_busy    <= 1'b1;
                tick_cnt  <= CNT_W'(`DBG_CLKS_PER_BIT - 1);
                bits_left <= 4'd9;
            end
        end
        else if (tick_cnt != '0)
            tick_cnt <= tick_cnt - 1'b1;
        else if (bits_left == '0)
            o_busy <= 1'b0;  // End of stop bit
        else
        begin
            frame     <= {1'b1, frame[9:1]};
            bits_left <= bits_left - 1'b1;
            tick_cnt  <= CNT_W'(`DBG_CLKS_PER_BIT - 1);
        end
    end

endmodule

//--- hdl/cmd_decoder.sv
`timescale 1ns/1ps
`include "dbg_params.svh"

module cmd_decoder
    import dbg_pkg::*;
(
    input  logic    i_clk,
    input  logic    i_reset_n,
    input  byte_t   i_rx_byte,
    input  logic    i_rx_valid,
    xfer_if.decoder xfer,
    output logic    o_cpu_reset_n,
    output logic    o_cpu_start,
    output logic    o_cpu_halt
);

    dec_state_t state;
    byte_t      cmd;   // Last accepted command byte

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            state         <= ST_IDLE;
            xfer.start    <= 1'b0;
            o_cpu_reset_n <= 1'b1;
            o_cpu_start   <= 1'b0;
            o_cpu_halt    <= 1'b0;
        end
        else
        begin
            xfer.start    <= 1'b0;
            o_cpu_reset_n <= 1'b1;
            o_cpu_start   <= 1'b0;
            o_cpu_halt    <= 1'b0;
            case (state)
                ST_IDLE:
                    if (i_rx_valid)
                    begin
                        cmd          <= i_rx_byte;
                        xfer.is_read <= (i_rx_byte == `DBG_CMD_READ);
                        case (i_rx_byte)
                            `DBG_CMD_RESET, `DBG_CMD_START, `DBG_CMD_HALT:
                                state <= ST_PULSE;
                            `DBG_CMD_READ, `DBG_CMD_WRITE:
                                state <= ST_ADDR_HI;
                            default:
                                state <= ST_IDLE;  // Unknown code dropped
                        endcase
                    end
                ST_ADDR_HI:
                    if (i_rx_valid)
                    begin
                        xfer.base[`DBG_ADDR_W-1:8] <= i_rx_byte[`DBG_ADDR_W-9:0];
                        xfer.to_pmem <= !xfer.is_read && i_rx_byte[`DBG_MEMSEL_BIT];
                        state        <= ST_ADDR_LO;
                    end
                ST_ADDR_LO:
                    if (i_rx_valid)
                    begin
                        xfer.base[7:0] <= i_rx_byte;
                        state          <= ST_LEN_HI;
                    end
                ST_LEN_HI:
                    if (i_rx_valid)
                    begin
                        xfer.count[`DBG_LEN_W-1:8] <= i_rx_byte[`DBG_LEN_W-9:0];
                        state <= ST_LEN_LO;
                    end
                ST_LEN_LO:
                    if (i_rx_valid)
                    begin
                        xfer.count[7:0] <= i_rx_byte;
                        if ({xfer.count[`DBG_LEN_W-1:8], i_rx_byte} == '0)
                            state <= ST_IDLE;  // Nothing to move
                        else
                        begin
                            xfer.start <= 1'b1;
                            state      <= ST_BUSY;
                        end
                    end
                ST_PULSE:
                begin
                    o_cpu_reset_n <= (cmd != `DBG_CMD_RESET);
                    o_cpu_start   <= (cmd == `DBG_CMD_START);
                    o_cpu_halt    <= (cmd == `DBG_CMD_HALT);
                    state         <= ST_IDLE;
                end
                ST_BUSY:
                    if (xfer.done)
                        state <= ST_IDLE;  // Rx bytes ignored until here
                default:
                    state <= ST_IDLE;
            endcase
        end
    end

endmodule

//--- hdl/mem_bridge.sv
`timescale 1ns/1ps
`include "dbg_params.svh"

module mem_bridge
    import dbg_pkg::*;
(
    input  logic   i_clk,
    input  logic   i_reset_n,
    xfer_if.bridge xfer,
    input  byte_t  i_rx_byte,
    input  logic   i_rx_valid,
    output byte_t  o_tx_byte,
    output logic   o_tx_start,
    input  logic   i_tx_busy,
    output addr_t  o_mem_address,
    output dword_t o_dmem_wdata,
    output logic   o_dmem_write,
    output logic   o_dmem_read,
    input  dword_t i_dmem_rdata,
    output pword_t o_pmem_wdata,
    output logic   o_pmem_write
);

    localparam int BCNT_W = $clog2(`DBG_DMEM_BYTES);

    bridge_state_t     state;
    logic [BCNT_W-1:0] byte_cnt;
    logic [BCNT_W-1:0] last_byte;
    len_t              remain;    // Words left in this transfer
    logic              mem_sel;   // 1 targets program memory
    dword_t            word_sr;   // Packs writes, unpacks reads

    assign last_byte    = mem_sel ? BCNT_W'(`DBG_PMEM_BYTES - 1) : BCNT_W'(`DBG_DMEM_BYTES - 1);
    assign o_dmem_wdata = word_sr;
    assign o_pmem_wdata = word_sr[`DBG_PWORD_W-1:0];

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            state        <= BR_IDLE;
            byte_cnt     <= '0;
            o_dmem_write <= 1'b0;
            o_pmem_write <= 1'b0;
            o_dmem_read  <= 1'b0;
            o_tx_start   <= 1'b0;
            xfer.done    <= 1'b0;
        end
        else
        begin
            o_dmem_write <= 1'b0;
            o_pmem_write <= 1'b0;
            o_dmem_read  <= 1'b0;
            o_tx_start   <= 1'b0;
            xfer.done    <= 1'b0;
            case (state)
                BR_IDLE:
                    if (xfer.start)
                    begin
                        o_mem_address <= xfer.base;
                        remain        <= xfer.count;
                        mem_sel       <= xfer.to_pmem;
                        byte_cnt      <= '0;
                        o_dmem_read   <= xfer.is_read;
                        state         <= xfer.is_read ? BR_FETCH : BR_COLLECT;
                    end
                BR_COLLECT:
                    if (i_rx_valid)
                    begin
                        word_sr <= {word_sr[`DBG_DWORD_W-9:0], i_rx_byte};  // MSB first
                        if (byte_cnt == last_byte)
                        begin
                            byte_cnt     <= '0;
                            o_dmem_write <= !mem_sel;
                            o_pmem_write <= mem_sel;
                            state        <= BR_COMMIT;
                        end
                        else
                            byte_cnt <= byte_cnt + 1'b1;
                    end
                BR_COMMIT:
                begin
                    o_mem_address <= o_mem_address + 1'b1;  // Wraps at 1024
                    remain        <= remain - 1'b1;
                    xfer.done     <= (remain == len_t'(1));
                    state         <= (remain == len_t'(1)) ? BR_IDLE : BR_COLLECT;
                end
                BR_FETCH:
                    state <= BR_LOAD;  // Memory answers on this edge
                BR_LOAD:
                begin
                    word_sr <= i_dmem_rdata;
                    state   <= BR_SEND;
                end
                BR_SEND:
                    if (!i_tx_busy)
                    begin
                        o_tx_byte  <= word_sr[`DBG_DWORD_W-1 -: 8];
                        word_sr    <= {word_sr[`DBG_DWORD_W-9:0], 8'h00};
                        o_tx_start <= 1'b1;
                        state      <= BR_WAIT;
                    end
                BR_WAIT:
                    // Busy is visible from the next cycle on
                    if (byte_cnt == last_byte)
                    begin
                        byte_cnt      <= '0;
                        o_mem_address <= o_mem_address + 1'b1;
                        remain        <= remain - 1'b1;
                        if (remain == len_t'(1))
                        begin
                            xfer.done <= 1'b1;
                            state     <= BR_IDLE;
                        end
                        else
                        begin
                            o_dmem_read <= 1'b1;
                            state       <= BR_FETCH;
                        end
                    end
                    else
                    begin
                        byte_cnt <= byte_cnt + 1'b1;
                        state    <= BR_SEND;
                    end
                default:
                    state <= BR_IDLE;
            endcase
        end
    end

endmodule

//--- hdl/debug_link_top.sv
`timescale 1ns/1ps

module debug_link_top
    import dbg_pkg::*;
(
    input  logic   i_clk,
    input  logic   i_reset_n,
    input  logic   i_rx,
    output logic   o_tx,
    output addr_t  o_mem_address,
    output dword_t o_dmem_wdata,
    output logic   o_dmem_write,
    output logic   o_dmem_read,
    input  dword_t i_dmem_rdata,
    output pword_t o_pmem_wdata,
    output logic   o_pmem_write,
    output logic   o_cpu_reset_n,
    output logic   o_cpu_start,
    output logic   o_cpu_halt
);

    byte_t rx_byte;
    logic  rx_valid;   // Shared by decoder and bridge
    byte_t tx_byte;
    logic  tx_start;
    logic  tx_busy;

    xfer_if xfer ();

    uart_rx u_uart_rx
    (
        .i_clk      (i_clk),
        .i_reset_n  (i_reset_n),
        .i_rx       (i_rx),
        .o_rx_byte  (rx_byte),
        .o_rx_valid (rx_valid)
    );

    cmd_decoder u_cmd_decoder
    (
        .i_clk         (i_clk),
        .i_reset_n     (i_reset_n),
        .i_rx_byte     (rx_byte),
        .i_rx_valid    (rx_valid),
        .xfer          (xfer.decoder),
        .o_cpu_reset_n (o_cpu_reset_n),
        .o_cpu_start   (o_cpu_start),
        .o_cpu_halt    (o_cpu_halt)
    );

    mem_bridge u_mem_bridge
    (
        .i_clk         (i_clk),
        .i_reset_n     (i_reset_n),
        .xfer          (xfer.bridge),
        .i_rx_byte     (rx_byte),
        .i_rx_valid    (rx_valid),
        .o_tx_byte     (tx_byte),
        .o_tx_start    (tx_start),
        .i_tx_busy     (tx_busy),
        .o_mem_address (o_mem_address),
        .o_dmem_wdata  (o_dmem_wdata),
        .o_dmem_write  (o_dmem_write),
        .o_dmem_read   (o_dmem_read),
        .i_dmem_rdata  (i_dmem_rdata),
        .o_pmem_wdata  (o_pmem_wdata),
        .o_pmem_write  (o_pmem_write)
    );

    uart_tx u_uart_tx
    (
        .i_clk      (i_clk),
        .i_reset_n  (i_reset_n),
        .i_tx_byte  (tx_byte),
        .i_tx_start (tx_start),
        .o_tx       (o_tx),
        .o_busy     (tx_busy)
    );

endmodule

//--- tests/tb_debug_link.sv
`timescale 1ns/1ps
`include "dbg_params.svh"

module tb_debug_link
    import dbg_pkg::*;
();

    localparam int CLKS        = `DBG_CLKS_PER_BIT;
    localparam int MAX_BYTES   = 3 + 37 + 21 + 37 + 15 + 20 * 37;  // Worst case line bytes
    localparam int WATCHDOG_NS = 2 * MAX_BYTES * 10 * CLKS * 100;

    logic   i_clk;
    logic   i_reset_n;
    logic   i_rx;
    logic   o_tx;
    addr_t  o_mem_address;
    dword_t o_dmem_wdata;
    logic   o_dmem_write;
    logic   o_dmem_read;
    dword_t i_dmem_rdata = '0;
    pword_t o_pmem_wdata;
    logic   o_pmem_write;
    logic   o_cpu_reset_n;
    logic   o_cpu_start;
    logic   o_cpu_halt;

    dword_t      dmem [0:1023];      // What the DUT sees
    dword_t      dmem_ref [0:1023];  // Built from the bytes sent
    pword_t      pmem [0:1023];
    pword_t      pmem_ref [0:1023];
    logic [42:0] exp_wr [$];         // {to_pmem, address, word}
    addr_t       exp_rd [$];         // Data memory read addresses in order
    byte_t       exp_tx [$];
    byte_t       tx_bits;
    byte_t       tx_exp;
    int          errors;
    int          pass_cnt;
    int          fail_cnt;
    int          n_reset;
    int          n_start;
    int          n_halt;
    int          seed;

    debug_link_top UUT (.*);

    always #50 i_clk = ~i_clk;

    initial
    begin
        #(WATCHDOG_NS);
        $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("*** TEST FAILED ***");
        $finish;
    end

    task automatic report_mismatch(input string name, input logic [31:0] exp_v,
                                   input logic [31:0] act_v);
        $display("mismatch at %0d ns: %s expected %h, got %h", $time, name, exp_v, act_v);
        errors++;
    endtask

    task automatic send_byte(input byte_t b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};
        repeat (10)
        begin
            @(negedge i_clk);
            i_rx  = frame[0];
            frame = {1'b1, frame[9:1]};
            repeat (CLKS - 1) @(negedge i_clk);
        end
    endtask

    task automatic send_header(input byte_t cmd, input addr_t base, input len_t len,
                               input logic sel);
        send_byte(cmd);
        send_byte({5'b0, sel, base[9:8]});
        send_byte(base[7:0]);
        send_byte({6'b0, len[9:8]});
        send_byte(len[7:0]);
    endtask

    task automatic wait_drained(input int limit);
        int t;
        t = 0;
        while ((exp_wr.size() != 0 || exp_rd.size() != 0 || exp_tx.size() != 0)
               && t < limit)
        begin
            @(negedge i_clk);
            t++;
        end
        if (exp_wr.size() != 0 || exp_rd.size() != 0 || exp_tx.size() != 0)
        begin
            $display("timeout: %0d memory writes, %0d memory reads and %0d tx bytes never came",
                     exp_wr.size(), exp_rd.size(), exp_tx.size());
            errors++;
            exp_wr.delete();
            exp_rd.delete();
            exp_tx.delete();
        end
        repeat (CLKS) @(negedge i_clk);  // Last stop bit ends
    endtask

    task automatic control_cmd(input int which);
        int t;
        int r0;
        int s0;
        int h0;
        r0 = n_reset;
        s0 = n_start;
        h0 = n_halt;
        send_byte(byte_t'(`DBG_CMD_RESET + which));
        t = 0;
        while (n_reset + n_start + n_halt == r0 + s0 + h0 && t < 4 * CLKS)
        begin
            @(negedge i_clk);
            t++;
        end
        repeat (4) @(negedge i_clk);
        if (n_reset - r0 != ((which == 0) ? 1 : 0))
            report_mismatch("o_cpu_reset_n low cycles", (which == 0) ? 1 : 0, n_reset - r0);
        if (n_start - s0 != ((which == 1) ? 1 : 0))
            report_mismatch("o_cpu_start high cycles", (which == 1) ? 1 : 0, n_start - s0);
        if (n_halt - h0 != ((which == 2) ? 1 : 0))
            report_mismatch("o_cpu_halt high cycles", (which == 2) ? 1 : 0, n_halt - h0);
    endtask

    task automatic write_cmd(input logic sel, input int len);
        addr_t  a;
        dword_t w;
        dword_t sw;
        int     i;
        a = addr_t'($urandom_range(0, 1023));
        send_header(`DBG_CMD_WRITE, a, len_t'(len), sel);
        for (i = 0; i < len; i++)
        begin
            w = $urandom();
            if (sel)
            begin
                w = {16'h0, w[15:0]};
                pmem_ref[a] = w[15:0];
                sw = {w[15:0], 16'h0};  // Two bytes, MSB first
            end
            else
            begin
                dmem_ref[a] = w;
                sw = w;
            end
            exp_wr.push_back({sel, a, w});
            repeat (sel ? 2 : 4)
            begin
                send_byte(sw[31:24]);
                sw = {sw[23:0], 8'h00};
            end
            a = a + 1'b1;  // Wraps at 1024
        end
        wait_drained(4 * CLKS);
    endtask

    task automatic read_cmd(input int len);
        addr_t  a;
        addr_t  base;
        dword_t w;
        int     i;
        base = addr_t'($urandom_range(0, 1023));
        a = base;
        for (i = 0; i < len; i++)
        begin
            w = $urandom();
            dmem[a] = w;
            dmem_ref[a] = w;
            exp_rd.push_back(a);
            exp_tx.push_back(w[31:24]);
            exp_tx.push_back(w[23:16]);
            exp_tx.push_back(w[15:8]);
            exp_tx.push_back(w[7:0]);
            a = a + 1'b1;
        end
        send_header(`DBG_CMD_READ, base, len_t'(len), 1'($urandom_range(0, 1)));
        wait_drained((4 * len + 2) * 10 * CLKS);
    endtask

    task automatic send_unknown();
        byte_t code;
        int    pulses;
        pulses = n_reset + n_start + n_halt;
        code = byte_t'($urandom_range(0, 255));
        while (code >= `DBG_CMD_RESET && code <= `DBG_CMD_WRITE)
            code = byte_t'($urandom_range(0, 255));
        send_byte(code);
        repeat (CLKS) @(negedge i_clk);
        if (n_reset + n_start + n_halt != pulses)
            report_mismatch("CPU control pulses", pulses, n_reset + n_start + n_halt);
    endtask

    task automatic random_cmd();
        int kind;
        kind = $urandom_range(0, 6);
        if (kind < 3)
            control_cmd(kind);
        else if (kind == 3)
            write_cmd(1'b0, $urandom_range(1, 8));
        else if (kind == 4)
            write_cmd(1'b1, $urandom_range(1, 8));
        else if (kind == 5)
            read_cmd($urandom_range(1, 8));
        else
            send_unknown();
    endtask

    task automatic check_write();
        logic [42:0] e;
        if (exp_wr.size() == 0)
        begin
            $display("unexpected memory write at %0d ns to address %h", $time, o_mem_address);
            errors++;
        end
        else
        begin
            e = exp_wr.pop_front();
            if (o_pmem_write !== e[42])
                report_mismatch("o_pmem_write", 32'(e[42]), 32'(o_pmem_write));
            if (o_dmem_write === e[42])
                report_mismatch("o_dmem_write", 32'(!e[42]), 32'(o_dmem_write));
            if (o_mem_address !== e[41:32])
                report_mismatch("o_mem_address", 32'(e[41:32]), 32'(o_mem_address));
            if (!e[42] && o_dmem_wdata !== e[31:0])
                report_mismatch("o_dmem_wdata", e[31:0], o_dmem_wdata);
            if (e[42] && o_pmem_wdata !== e[15:0])
                report_mismatch("o_pmem_wdata", 32'(e[15:0]), 32'(o_pmem_wdata));
        end
        if (o_dmem_write)
            dmem[o_mem_address] = o_dmem_wdata;
        if (o_pmem_write)
            pmem[o_mem_address] = o_pmem_wdata;
    endtask

    task automatic check_read();
        addr_t exp_a;
        if (exp_rd.size() == 0)
        begin
            $display("unexpected data memory read at %0d ns from address %h",
                     $time, o_mem_address);
            errors++;
        end
        else
        begin
            exp_a = exp_rd.pop_front();
            if (o_mem_address !== exp_a)
                report_mismatch("o_mem_address on read", 32'(exp_a), 32'(o_mem_address));
        end
    endtask

    task automatic record_result(input string name, input int errs_before);
        if (errors == errs_before)
        begin
            pass_cnt++;
            $display("%s: ok", name);
        end
        else
        begin
            fail_cnt++;
            $display("%s: failed with %0d errors", name, errors - errs_before);
        end
    endtask

    always @(negedge i_clk)
    begin
        if (!o_cpu_reset_n)
            n_reset++;
        if (o_cpu_start)
            n_start++;
        if (o_cpu_halt)
            n_halt++;
    end

    always @(negedge i_clk)
    begin
        if (o_dmem_read)
        begin
            check_read();
            i_dmem_rdata = dmem[o_mem_address];  // Taken by the DUT two edges later
        end
        if (o_dmem_write || o_pmem_write)
            check_write();
    end

    // Serial monitor, samples o_tx at bit centers
    always @(negedge i_clk)
    begin
        if (o_tx === 1'b0)
        begin
            repeat (CLKS / 2 - 1) @(negedge i_clk);
            repeat (8)
            begin
                repeat (CLKS) @(negedge i_clk);
                tx_bits = {o_tx, tx_bits[7:1]};  // LSB first
            end
            repeat (CLKS) @(negedge i_clk);
            if (o_tx !== 1'b1)
            begin
                $display("bad stop bit on o_tx at %0d ns", $time);
                errors++;
            end
            else if (exp_tx.size() == 0)
            begin
                $display("unexpected byte %h on o_tx at %0d ns", tx_bits, $time);
                errors++;
            end
            else
            begin
                tx_exp = exp_tx.pop_front();
                if (tx_bits !== tx_exp)
                    report_mismatch("o_tx byte", 32'(tx_exp), 32'(tx_bits));
            end
        end
    end

    initial
    begin
        int e;
        int i;
        seed      = $urandom(68939);
        i_clk     = 1'b0;
        i_reset_n = 1'b0;
        i_rx      = 1'b1;
        dmem      = '{default: '0};
        dmem_ref  = '{default: '0};
        pmem      = '{default: '0};
        pmem_ref  = '{default: '0};
        repeat (4) @(posedge i_clk);
        @(negedge i_clk);
        i_reset_n = 1'b1;
        repeat (2) @(negedge i_clk);

        e = errors;
        control_cmd(0);
        control_cmd(1);
        control_cmd(2);
        record_result("control commands", e);

        e = errors;
        write_cmd(1'b0, $urandom_range(1, 8));
        record_result("data memory write", e);

        e = errors;
        write_cmd(1'b1, $urandom_range(1, 8));
        record_result("program memory write", e);

        e = errors;
        read_cmd($urandom_range(1, 8));
        record_result("data memory read", e);

        e = errors;
        send_unknown();
        send_header(`DBG_CMD_WRITE, addr_t'($urandom_range(0, 1023)), len_t'(0), 1'b0);
        write_cmd(1'b0, 1);  // Must still work after the dropped bytes
        record_result("unknown command and zero length", e);

        e = errors;
        for (i = 0; i < 20; i++)
            random_cmd();
        foreach (dmem[k])
        begin
            if (dmem[k] !== dmem_ref[k])
                report_mismatch("data memory word", dmem_ref[k], dmem[k]);
            if (pmem[k] !== pmem_ref[k])
                report_mismatch("program memory word", 32'(pmem_ref[k]), 32'(pmem[k]));
        end
        record_result("random mix", e);

        $display("tests passed: %0d, tests failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && errors == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

//--- list.f
+incdir+common
common/dbg_pkg.sv
common/xfer_if.sv
uart/uart_rx.sv
uart/uart_tx.sv
hdl/cmd_decoder.sv
hdl/mem_bridge.sv
hdl/debug_link_top.sv
tests/tb_debug_link.sv

//--- run.sh
#!/usr/bin/env bash
# Build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1

verilator --binary -f list.f --top-module tb_debug_link -o tb_debug_link \
    && ./obj_dir/tb_debug_link | tee /dev/stderr | grep -qF "*** TEST PASSED ***" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
